/* pp_top.f */
hw/pp_pkg.sv
hw/pp_cfg.sv
hw/pp_chunk_ram.sv
hw/pp_fifo.sv
hw/pp_rd_ctrl.sv
hw/pp_sm.sv
hw/pp_top.sv
bench/pp_checker.sv
bench/pp_monitor.sv
bench/pp_tb.sv

/* Makefile */
SIM      = verilator
TOP      = pp_tb
FILELIST = pp_top.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/pp_tb.sv */
// Random packets through the path parser slice, seeded xorshift stimulus.
// Upstream waits for path_parser_ready before the first beat of each packet.

module pp_tb
   import pp_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [31:0] SEED          = 32'hd59bb7d2;
   localparam int          PKTS_PER_TEST = 8;
   localparam int          NUM_PKTS      = 6 * PKTS_PER_TEST;
   localparam int          LIMIT_CYCLES  = NUM_PKTS * 400 + 2000;

   logic                     clk = 1'b0;
   logic                     rst;
   logic                     beat_valid;
   pp_beat_t                 beat;
   logic                     meta_valid;
   logic [1:0]               meta_id;
   rci_t                     meta_rci;
   logic                     hop_ready = 1'b0;
   logic                     cfg_wr;
   logic                     cfg_addr;
   logic [HOP_CNT_NBITS-1:0] cfg_wdata;
   logic                     path_parser_ready;
   logic                     hop_valid;
   hop_out_t                 hop_out;

   logic [31:0] rng     = SEED;
   logic [31:0] bp_rng  = ~SEED;         // Separate stream for hop_ready.
   logic        bp_on   = 1'b0;
   logic        noise   = 1'b0;          // Foreign beats and metadata in between.
   logic [1:0]  id_cur  = 2'd0;
   int          max_cur = MAX_HOPS_RESET;
   string       test_name = "";
   int          assert_fails;

   always #10 clk = ~clk;

   pp_top dut0 (.*);

   pp_monitor mon0 (.clk, .rst, .path_parser_ready, .hop_valid, .hop_ready, .hop_out);

   bind pp_sm pp_checker chk0 (.clk, .rst, .hop_valid, .hop_ready, .hop_out);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'(next_rand() % 32'(hi - lo + 1));
   endfunction

   always @(posedge clk) begin
      bp_rng    <= xorshift(bp_rng);
      hop_ready <= !bp_on || bp_rng[3];
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks.
   task automatic send_noise();
      logic [31:0] r;
      logic [1:0]  other;
      pp_beat_t    b;
      r      = next_rand();
      other  = (r[17:16] == 2'd0) ? 2'd1 : r[17:16];
      b.data = {r, ~r};
      b.eop  = r[5];
      b.len  = r[12:8];
      b.id   = id_cur ^ other;                  // Never the configured id.
      @(posedge clk);
      beat_valid <= 1'b1;
      beat       <= b;
      meta_valid <= r[20];
      meta_id    <= id_cur ^ other;
      meta_rci   <= r[31:24];
   endtask

   task automatic send_packet(input int n, input int len, input int rci);
      logic [DATA_NBITS-1:0] beats [16];
      pp_beat_t              b;
      for (int i = 0; i < 16; i++) begin
         beats[i][31:0]  = next_rand();
         beats[i][63:32] = next_rand();
      end
      beats[0][7:0] = 8'(n);
      mon0.expect_packet(test_name, beats, len, rci, max_cur);
      @(negedge clk);
      while (!path_parser_ready) @(negedge clk);
      for (int i = 0; i < len; i++) begin
         if (noise && (next_rand() % 3) == 0) send_noise();
         b.data = beats[i];
         b.eop  = (i == len - 1);
         b.len  = LEN_NBITS'(len);
         b.id   = id_cur;
         @(posedge clk);
         beat_valid <= 1'b1;
         beat       <= b;
         meta_valid <= b.eop;                   // One rci with the last beat.
         meta_id    <= id_cur;
         meta_rci   <= rci_t'(rci);
      end
      @(posedge clk);
      beat_valid <= 1'b0;
      meta_valid <= 1'b0;
   endtask

   task automatic send_good();
      int n;
      int len;
      n   = rand_range(1, max_cur);
      len = rand_range((n + 3) / 4 + 1, 16);
      send_packet(n, len, rand_range(0, n - 1));
   endtask

   task automatic send_bad(input int k);
      int n;
      int len;
      int rci;
      n   = rand_range(1, 6);
      len = rand_range((n + 3) / 4 + 1, 16);
      rci = 0;
      case (k % 4)
         0: n = 0;
         1: begin
            n   = rand_range(7, 20);            // Above max_hops.
            len = 16;
         end
         2: begin
            n   = rand_range(5, 6);             // More hops than one beat holds.
            len = 2;
         end
         default: rci = rand_range(n, n + 3);
      endcase
      send_packet(n, len, rci);
   endtask

   task automatic write_cfg(input logic addr, input logic [HOP_CNT_NBITS-1:0] data);
      @(posedge clk);
      cfg_wr    <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      @(posedge clk);
      cfg_wr    <= 1'b0;
   endtask

   task automatic drain();
      @(negedge clk);
      while (mon0.outstanding != 0) @(negedge clk);
      repeat (4) @(negedge clk);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence.
   initial begin
      rst        <= 1'b1;
      beat_valid <= 1'b0;
      beat       <= '0;
      meta_valid <= 1'b0;
      meta_id    <= 2'd0;
      meta_rci   <= '0;
      cfg_wr     <= 1'b0;
      cfg_addr   <= 1'b0;
      cfg_wdata  <= '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      test_name = "good";
      repeat (PKTS_PER_TEST) send_good();
      test_name = "id_filter";
      noise     = 1'b1;
      repeat (PKTS_PER_TEST) send_good();
      noise     = 1'b0;

      test_name = "hdr_err";
      drain();
      write_cfg(1'b1, 8'd6);
      max_cur = 6;
      for (int k = 0; k < PKTS_PER_TEST; k++) send_bad(k);
      drain();
      write_cfg(1'b1, 8'(MAX_HOPS_RESET));
      max_cur = MAX_HOPS_RESET;

      test_name = "backpressure";
      bp_on     = 1'b1;
      repeat (PKTS_PER_TEST) send_good();
      test_name = "pingpong";
      bp_on     = 1'b0;
      repeat (PKTS_PER_TEST) send_good();

      test_name = "reconfig";
      drain();
      write_cfg(1'b0, 8'd2);
      id_cur = 2'd2;
      noise  = 1'b1;
      bp_on  = 1'b1;
      repeat (PKTS_PER_TEST) send_good();
      drain();

      assert_fails = dut0.u_sm.chk0.fails;
      mon0.report(assert_fails);
      if (mon0.errors == 0 && assert_fails == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog.
   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles with %0d records still outstanding",
               LIMIT_CYCLES, mon0.outstanding);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* bench/pp_monitor.sv */
// Reference model and comparator for the hop output stream.
// Transfers are checked at the falling edge before the edge that takes them.

module pp_monitor
   import pp_pkg::*;
(
   input logic     clk,
   input logic     rst,
   input logic     path_parser_ready,
   input logic     hop_valid,
   input logic     hop_ready,
   input hop_out_t hop_out
);
   timeunit 1ns;
   timeprecision 1ps;

   hop_out_t exp_q [$];
   string    name_q [$];
   hop_out_t exp_rec;
   string    exp_name;
   logic     rst_q;              // rst as seen at the last rising edge.
   int       outstanding = 0;
   int       errors      = 0;
   int       checked     = 0;
   int       packets     = 0;

   function automatic string show_rec(input hop_out_t r);
      return $sformatf("%h sop %b eop %b err %b", r.data, r.sop, r.eop, r.error);
   endfunction

   // Header rule applied to one packet.
   task automatic expect_packet(input string name, input logic [DATA_NBITS-1:0] beats [16],
                                input int len, input int rci, input int max_hops);
      int       n;
      hop_out_t r;
      n = int'(beats[0][7:0]);
      packets++;
      if (n == 0 || n > max_hops || n > 4 * (len - 1) || rci >= n) begin
         r = '{data: '0, sop: 1'b1, eop: 1'b1, error: 1'b1};
         exp_q.push_back(r);
         name_q.push_back(name);
         outstanding++;
      end else begin
         for (int i = rci; i < n; i++) begin
            r.data  = beats[1 + i / 4][16 * (i % 4) +: 16];
            r.sop   = (i == rci);
            r.eop   = (i == n - 1);
            r.error = 1'b0;
            exp_q.push_back(r);
            name_q.push_back(name);
            outstanding++;
         end
      end
   endtask

   always @(posedge clk) begin
      rst_q <= rst;
   end

   // Ready is low through reset and the first cycle after it.
   always @(negedge clk) begin
      if (rst_q === 1'b1 && path_parser_ready !== 1'b0) begin
         $display("error reset expected ready %b actual ready %b", 1'b0, path_parser_ready);
         errors++;
      end
   end

   always @(negedge clk) begin
      if (!rst && hop_valid && hop_ready) begin
         if (exp_q.size() == 0) begin
            $display("unexpected record %s while no packet was pending", show_rec(hop_out));
            errors++;
         end else begin
            exp_rec  = exp_q.pop_front();
            exp_name = name_q.pop_front();
            outstanding--;
            checked++;
            if (hop_out !== exp_rec) begin
               $display("error %s expected %s actual %s", exp_name, show_rec(exp_rec),
                        show_rec(hop_out));
               errors++;
            end
         end
      end
   end

   task automatic report(input int assert_fails);
      if (exp_q.size() != 0) begin
         $display("%0d expected records never came out", exp_q.size());
         errors++;
      end
      $display("packets %0d, records %0d, errors %0d, assertion failures %0d",
               packets, checked, errors, assert_fails);
   endtask

endmodule

/* bench/pp_checker.sv */
// Protocol checks on the sequencer output, bound into pp_sm.

module pp_checker
   import pp_pkg::*;
(
   input logic     clk,
   input logic     rst,
   input logic     hop_valid,
   input logic     hop_ready,
   input hop_out_t hop_out
);
   timeunit 1ns;
   timeprecision 1ps;

   int   fails = 0;
   logic in_pkt;   // Between a sop and its eop.

   always_ff @(posedge clk) begin
      if (rst) begin
         in_pkt <= 1'b0;
      end else if (hop_valid && hop_ready) begin
         in_pkt <= !hop_out.eop;
      end
   end

   idle_after_reset: assert property (@(posedge clk) rst |=> !hop_valid)
      else begin
         $error("hop_valid high right after reset");
         fails++;
      end

   hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
      hop_valid && !hop_ready |=> hop_valid && $stable(hop_out))
      else begin
         $error("output record changed while stalled");
         fails++;
      end

   sop_opens_packet: assert property (@(posedge clk) disable iff (rst)
      hop_valid |-> hop_out.sop == !in_pkt)
      else begin
         $error("sop and eop out of order");
         fails++;
      end

endmodule

/* hw/pp_top.sv */
// Path parser slice. Upstream starts a packet only while path_parser_ready
// is high; packets are at most 16 beats, one rci word per accepted packet.

module pp_top
   import pp_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     beat_valid,
   input  pp_beat_t                 beat,
   input  logic                     meta_valid,
   input  logic [1:0]               meta_id,
   input  rci_t                     meta_rci,
   input  logic                     hop_ready,
   input  logic                     cfg_wr,
   input  logic                     cfg_addr,
   input  logic [HOP_CNT_NBITS-1:0] cfg_wdata,
   output logic                     path_parser_ready,
   output logic                     hop_valid,
   output hop_out_t                 hop_out
);

   pp_cfg_t                        cfg;
   logic                           wr_bank;
   logic                           wr_bank_nxt;
   logic                           rd_bank;
   logic [CHUNK_DEPTH_NBITS-1:0]   beat_cnt;
   logic                           wen;
   logic                           meta_push;
   logic [1:0]                     eop_wr;
   logic [1:0]                     start_q;
   logic [1:0]                     busy;
   logic [1:0]                     occupied;
   logic [LEN_NBITS-1:0]           len_q [2];
   logic [DATA_NBITS-1:0]          ram_rdata;
   logic [1:0]                     rd;
   logic [CHUNK_DEPTH_NBITS-1:0]   raddr [2];
   logic [1:0]                     push, fifo_full, hop_empty, hop_pop, done;
   hop_rec_t                       rec [2];
   hop_rec_t                       hop_rec [2];
   logic                           meta_empty, meta_pop, bank_toggle;
   rci_t                           rci_head;

   assign wen         = beat_valid && (beat.id == cfg.pp_id);
   assign meta_push   = meta_valid && (meta_id == cfg.pp_id);
   assign eop_wr      = {wen && beat.eop && wr_bank, wen && beat.eop && !wr_bank};
   assign wr_bank_nxt = wr_bank ^ (wen && beat.eop);
   assign occupied    = busy | start_q | eop_wr;    // Bank holds an unparsed packet.

   //////////////////////////////////////////////////////////////////////
   // Write side and ready.
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_bank           <= 1'b0;
         rd_bank           <= 1'b0;
         beat_cnt          <= '0;
         start_q           <= 2'b00;
         path_parser_ready <= 1'b0;
      end else begin
         wr_bank           <= wr_bank_nxt;
         rd_bank           <= rd_bank ^ bank_toggle;
         start_q           <= eop_wr;
         path_parser_ready <= !occupied[wr_bank_nxt];
         if (wen) beat_cnt <= beat.eop ? '0 : beat_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      for (int b = 0; b < 2; b++) begin
         if (eop_wr[b]) len_q[b] <= beat.len;
      end
   end

   pp_cfg u_cfg (.clk, .rst, .cfg_wr, .cfg_addr, .cfg_wdata, .cfg);

   pp_chunk_ram u_ram (
      .clk, .wr(wen), .waddr({wr_bank, beat_cnt}), .din(beat.data),
      .rd(rd[rd_bank]), .raddr({rd_bank, raddr[rd_bank]}), .dout(ram_rdata));

   //////////////////////////////////////////////////////////////////////
   // One parser and hop FIFO per bank.
   for (genvar b = 0; b < 2; b++) begin : g_bank
      pp_rd_ctrl u_rd_ctrl (
         .clk, .rst, .start(start_q[b]), .len(len_q[b]), .cfg,
         .rd_grant(rd_bank == b), .rdata(ram_rdata), .fifo_full(fifo_full[b]),
         .done(done[b]), .busy(busy[b]), .rd(rd[b]), .raddr(raddr[b]),
         .push(push[b]), .rec(rec[b]));

      pp_fifo #(.T(hop_rec_t), .DEPTH(HOP_FIFO_DEPTH)) u_hop_fifo (
         .clk, .rst, .push(push[b]), .wdata(rec[b]), .pop(hop_pop[b]),
         .rdata(hop_rec[b]), .empty(hop_empty[b]), .full(fifo_full[b]));
   end

   pp_fifo #(.T(rci_t), .DEPTH(META_FIFO_DEPTH)) u_meta_fifo (
      .clk, .rst, .push(meta_push), .wdata(meta_rci), .pop(meta_pop),
      .rdata(rci_head), .empty(meta_empty), .full());

   pp_sm u_sm (
      .clk, .rst, .hop_rec0(hop_rec[0]), .hop_empty0(hop_empty[0]),
      .hop_rec1(hop_rec[1]), .hop_empty1(hop_empty[1]), .meta_empty,
      .meta_rci(rci_head), .hop_ready, .hop_pop0(hop_pop[0]), .hop_pop1(hop_pop[1]),
      .meta_pop, .done0(done[0]), .done1(done[1]), .bank_toggle, .hop_valid, .hop_out);

endmodule

/* hw/pp_sm.sv */
// Output sequencer. Serves the two hop FIFOs in ping-pong order, one packet
// each, and needs the packet's rci in the meta FIFO before it starts.

module pp_sm
   import pp_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  hop_rec_t hop_rec0,
   input  logic     hop_empty0,
   input  hop_rec_t hop_rec1,
   input  logic     hop_empty1,
   input  logic     meta_empty,
   input  rci_t     meta_rci,
   input  logic     hop_ready,
   output logic     hop_pop0,
   output logic     hop_pop1,
   output logic     meta_pop,
   output logic     done0,
   output logic     done1,
   output logic     bank_toggle,
   output logic     hop_valid,
   output hop_out_t hop_out
);

   logic     bank;
   rci_t     idx;          // Index of the hop at the FIFO head.
   logic     first;        // Next emitted record gets sop.
   hop_rec_t cur_rec;
   logic     avail;
   logic     slot;
   logic     below;
   logic     skip;
   logic     take;
   logic     emit;
   logic     fin;
   logic     bad;

   assign cur_rec = bank ? hop_rec1 : hop_rec0;
   assign avail   = !(bank ? hop_empty1 : hop_empty0) && !meta_empty;
   assign slot    = !hop_valid || hop_ready;
   assign below   = (idx < meta_rci);
   assign skip    = !cur_rec.error && !cur_rec.last && below;   // Dropped silently.
   assign take    = avail && (skip || slot);
   assign emit    = take && !skip;
   assign fin     = take && cur_rec.last;
   // Last hop reached below rci means rci >= N.
   assign bad     = cur_rec.error || below;

   assign hop_pop0    = take && !bank;
   assign hop_pop1    = take && bank;
   assign meta_pop    = fin;
   assign done0       = fin && !bank;
   assign done1       = fin && bank;
   assign bank_toggle = fin;

   always_ff @(posedge clk) begin
      if (rst) begin
         bank      <= 1'b0;
         idx       <= '0;
         first     <= 1'b1;
         hop_valid <= 1'b0;
      end else begin
         if (fin) begin
            bank  <= ~bank;
            idx   <= '0;
            first <= 1'b1;
         end else if (take) begin
            idx <= idx + 1'b1;
            if (emit) first <= 1'b0;
         end
         if (emit) hop_valid <= 1'b1;
         else if (hop_ready) hop_valid <= 1'b0;
      end
   end

   // Output record holds until it is taken.
   always_ff @(posedge clk) begin
      if (emit) begin
         hop_out.data  <= bad ? '0 : cur_rec.hop;
         hop_out.sop   <= first;
         hop_out.eop   <= bad || cur_rec.last;
         hop_out.error <= bad;
      end
   end

endmodule

/* hw/pp_rd_ctrl.sv */
// Header parser for one chunk bank. Reads beat 0, checks the hop count and
// pushes one hop record per cycle at most. Holds the bank until done.

module pp_rd_ctrl
   import pp_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start,
   input  logic [LEN_NBITS-1:0]          len,
   input  pp_cfg_t                       cfg,
   input  logic                          rd_grant,
   input  logic [DATA_NBITS-1:0]         rdata,
   input  logic                          fifo_full,
   input  logic                          done,
   output logic                          busy,
   output logic                          rd,
   output logic [CHUNK_DEPTH_NBITS-1:0]  raddr,
   output logic                          push,
   output hop_rec_t                      rec
);

   typedef enum logic [1:0] {IDLE, HEADER, HOPS, WAIT_DONE} state_t;

   state_t                             state;
   logic [LEN_NBITS-1:0]               len_q;
   logic [HOP_CNT_NBITS-1:0]           n_q;
   logic [HOP_CNT_NBITS-1:0]           hop_idx;
   logic [HOP_CNT_NBITS-1:0]           n_hdr;
   logic [HOP_CNT_NBITS-1:0]           len_hops;
   logic [HOPS_PER_BEAT-1:0][HOP_NBITS-1:0] beat_q;
   logic                               pend;       // Read data arrives this cycle.
   logic                               have_beat;
   logic                               err_q;
   logic                               hdr_err;
   logic                               last_hop;

   assign n_hdr    = rdata[HOP_CNT_LSB +: HOP_CNT_NBITS];
   assign len_hops = HOP_CNT_NBITS'(len_q - 1'b1) << LANE_NBITS;  // 4 hops per beat.
   assign hdr_err  = (n_hdr == '0) || (n_hdr > cfg.max_hops) || (n_hdr > len_hops);
   assign last_hop = (hop_idx == n_q - 1'b1);
   assign busy     = (state != IDLE);

   always_comb begin
      rd    = 1'b0;
      raddr = '0;                               // Header beat.
      push  = 1'b0;
      rec   = '0;
      case (state)
         HEADER: rd = rd_grant && !pend;
         HOPS: begin
            if (err_q) begin
               push      = !fifo_full;
               rec.last  = 1'b1;
               rec.error = 1'b1;
            end else if (have_beat) begin
               push     = !fifo_full;
               rec.hop  = beat_q[hop_idx[LANE_NBITS-1:0]];
               rec.last = last_hop;
            end else begin
               rd    = rd_grant && !pend;
               raddr = CHUNK_DEPTH_NBITS'(HOP_BEAT0) +
                       hop_idx[LANE_NBITS +: CHUNK_DEPTH_NBITS];
            end
         end
         default: ;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Control.
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         pend      <= 1'b0;
         have_beat <= 1'b0;
         hop_idx   <= '0;
      end else begin
         pend <= rd;
         case (state)
            IDLE: if (start) state <= HEADER;
            HEADER: begin
               if (pend) begin
                  state     <= HOPS;
                  hop_idx   <= '0;
                  have_beat <= 1'b0;
               end
            end
            HOPS: begin
               if (pend) have_beat <= 1'b1;
               if (push) begin
                  hop_idx <= hop_idx + 1'b1;
                  if (&hop_idx[LANE_NBITS-1:0]) have_beat <= 1'b0;  // Beat used up.
                  if (err_q || last_hop) state <= WAIT_DONE;
               end
            end
            WAIT_DONE: if (done) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // Packet length, header result and current beat.
   always_ff @(posedge clk) begin
      if (state == IDLE && start) len_q <= len;
      if (state == HEADER && pend) begin
         n_q   <= n_hdr;
         err_q <= hdr_err;
      end
      if (state == HOPS && pend) beat_q <= rdata;
   end

endmodule

/* hw/pp_fifo.sv */
// Synchronous FIFO with first-word-fall-through reads. DEPTH must be a
// power of two. Push on full and pop on empty are ignored.

module pp_fifo #(
   parameter type T     = logic [7:0],
   parameter int  DEPTH = 4
) (
   input  logic clk,
   input  logic rst,
   input  logic push,
   input  T     wdata,
   input  logic pop,
   output T     rdata,
   output logic empty,
   output logic full
);

   localparam int PTR_NBITS = $clog2(DEPTH);
   localparam int CNT_NBITS = $clog2(DEPTH + 1);

   T                     mem [DEPTH];
   logic [PTR_NBITS-1:0] wr_ptr;
   logic [PTR_NBITS-1:0] rd_ptr;
   logic [CNT_NBITS-1:0] count;
   logic                 do_push;
   logic                 do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;
   assign empty   = (count == '0);
   assign full    = (count == CNT_NBITS'(DEPTH));
   assign rdata   = mem[rd_ptr];                  // Head word, no read latency.

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* hw/pp_chunk_ram.sv */
// Two chunk banks of 16 beats in one memory; the top address bit picks the bank.
// One write and one read port, read data one cycle after rd.

module pp_chunk_ram
   import pp_pkg::*;
(
   input  logic                         clk,
   input  logic                         wr,
   input  logic [CHUNK_DEPTH_NBITS:0]   waddr,
   input  logic [DATA_NBITS-1:0]        din,
   input  logic                         rd,
   input  logic [CHUNK_DEPTH_NBITS:0]   raddr,
   output logic [DATA_NBITS-1:0]        dout
);

   localparam int WORDS = 2 << CHUNK_DEPTH_NBITS;

   logic [DATA_NBITS-1:0] mem [WORDS];

   always_ff @(posedge clk) begin
      if (wr) begin
         mem[waddr] <= din;
      end
   end

   // Registered read, holds between reads.
   always_ff @(posedge clk) begin
      if (rd) begin
         dout <= mem[raddr];
      end
   end

endmodule

/* hw/pp_cfg.sv */
// Configuration registers of the slice. Write only between packets;
// a change while a packet is in flight is not guarded.

module pp_cfg
   import pp_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfg_wr,
   input  logic                     cfg_addr,
   input  logic [HOP_CNT_NBITS-1:0] cfg_wdata,
   output pp_cfg_t                  cfg
);

   //////////////////////////////////////////////////////////////////////
   // Register map.
   //   0: path id, bits 1:0.
   //   1: max_hops.
   localparam logic ADDR_PP_ID    = 1'b0;
   localparam logic ADDR_MAX_HOPS = 1'b1;

   logic [1:0]               pp_id_q;
   logic [HOP_CNT_NBITS-1:0] max_hops_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         pp_id_q    <= 2'd0;
         max_hops_q <= HOP_CNT_NBITS'(MAX_HOPS_RESET);
      end else if (cfg_wr) begin
         case (cfg_addr)
            ADDR_PP_ID:    pp_id_q    <= cfg_wdata[1:0];
            ADDR_MAX_HOPS: max_hops_q <= cfg_wdata;
            default: ;
         endcase
      end
   end

   assign cfg.pp_id    = pp_id_q;
   assign cfg.max_hops = max_hops_q;

endmodule

/* hw/pp_pkg.sv */
// Shared widths, header fields and record types of the path parser slice.
// Packets are at most 16 beats; one bank holds exactly one packet.

package pp_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths.
   localparam int DATA_NBITS        = 64;
   localparam int CHUNK_DEPTH_NBITS = 4;   // 16 beats per bank.
   localparam int LEN_NBITS         = 5;
   localparam int HOP_NBITS         = 16;
   localparam int HOPS_PER_BEAT     = 4;
   localparam int LANE_NBITS        = $clog2(HOPS_PER_BEAT);
   localparam int RCI_NBITS         = 8;

   // Header layout.
   localparam int HOP_CNT_LSB   = 0;        // Hop count sits in beat 0.
   localparam int HOP_CNT_NBITS = 8;
   localparam int HOP_BEAT0     = 1;        // First beat holding hops.

   localparam int HOP_FIFO_DEPTH  = 8;
   localparam int META_FIFO_DEPTH = 4;
   localparam int MAX_HOPS_RESET  = 16;

   //////////////////////////////////////////////////////////////////////
   // Records.
   typedef logic [RCI_NBITS-1:0] rci_t;

   typedef struct packed {
      logic [DATA_NBITS-1:0] data;
      logic                  eop;
      logic [LEN_NBITS-1:0]  len;   // Valid on the eop beat.
      logic [1:0]            id;
   } pp_beat_t;

   typedef struct packed {
      logic [HOP_NBITS-1:0] hop;
      logic                 last;
      logic                 error;
   } hop_rec_t;

   typedef struct packed {
      logic [HOP_NBITS-1:0] data;
      logic                 sop;
      logic                 eop;
      logic                 error;
   } hop_out_t;

   typedef struct packed {
      logic [1:0]               pp_id;
      logic [HOP_CNT_NBITS-1:0] max_hops;
   } pp_cfg_t;

endpackage
